//--- source/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////////////////////////
	// address, instruction and block widths
	//////////////////////////////////////////////////

	// byte address from the pc
	typedef logic [31:0] addr_t;

	// one instruction word
	typedef logic [31:0] inst_t;

	// one cache block, two instruction words
	// lower word at the lower address
	typedef logic [63:0] block_t;

	// byte offset bits inside one block
	localparam int BLOCK_OFFSET_BITS = 3;

	// pc after reset
	localparam addr_t RESET_PC = 32'h0000_0000;

	//////////////////////////////////////////////////
	// memory side of the fetch unit
	//////////////////////////////////////////////////

	// transaction tag from memory
	// zero means no transaction, so a zero response is a retry
	typedef logic [3:0] mem_tag_t;

	// command to memory
	// store is kept for the encoding only, fetch never writes
	typedef enum logic [1:0] {
		CMD_NONE  = 2'h0,
		CMD_LOAD  = 2'h1,
		CMD_STORE = 2'h2
	} mem_command_t;

	// lines above the block offset are split as
	//   [offset + index +: tag] [offset +: index] [0 +: offset]
	// anything above the tag is ignored by the cache

endpackage

//--- source/icache_mem.sv
`timescale 1ns/1ns

module icache_mem #(
	parameter int INDEX_BITS = 5,
	parameter int TAG_BITS   = 8
) (
	input  logic                  clock,
	input  logic                  rst_n,
	// lookup side, driven by the pc
	input  fetch_pkg::addr_t      pc,
	// fill side, driven by the miss controller
	input  logic                  fill_en,
	input  logic [INDEX_BITS-1:0] fill_index,
	input  logic [TAG_BITS-1:0]   fill_tag,
	input  fetch_pkg::block_t     fill_block,
	// lookup result, same cycle
	output logic                  lookup_hit,
	output fetch_pkg::block_t     lookup_block
);

	import fetch_pkg::*;

	// one line per index, direct mapped
	localparam int NUM_LINES = 1 << INDEX_BITS;

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	// valid bit per line
	logic [NUM_LINES-1:0] line_valid;
	// stored tag per line
	logic [TAG_BITS-1:0]  line_tag   [NUM_LINES];
	// stored block per line
	block_t               line_block [NUM_LINES];

	// pc split into index and tag
	logic [INDEX_BITS-1:0] pc_index;
	logic [TAG_BITS-1:0]   pc_tag;

	assign pc_index = pc[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign pc_tag   = pc[BLOCK_OFFSET_BITS + INDEX_BITS +: TAG_BITS];

	//////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////

	// hit when line valid and tag matches
	assign lookup_hit   = line_valid[pc_index] && (line_tag[pc_index] == pc_tag);
	// data goes out regardless, only meaningful with hit
	assign lookup_block = line_block[pc_index];

	//////////////////////////////////////////////////
	// fill
	//////////////////////////////////////////////////

	// valid bits, all lines empty after reset
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			line_valid <= '0;
		end else if (fill_en) begin
			line_valid[fill_index] <= 1'b1;
		end
	end

	// tag and data arrays
	// written on the fill, seen by lookup from the next cycle
	always_ff @(posedge clock) begin
		if (fill_en) begin
			line_tag[fill_index]   <= fill_tag;
			line_block[fill_index] <= fill_block;
		end
	end

endmodule

//--- source/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl #(
	parameter int INDEX_BITS = 5,
	parameter int TAG_BITS   = 8
) (
	input  logic                    clock,
	input  logic                    rst_n,
	// current fetch address and its lookup result
	input  fetch_pkg::addr_t        pc,
	input  logic                    lookup_hit,
	// memory answers
	input  fetch_pkg::mem_tag_t     mem2proc_response,
	input  fetch_pkg::mem_tag_t     mem2proc_tag,
	input  fetch_pkg::block_t       mem2proc_data,
	// memory request
	output fetch_pkg::mem_command_t proc2mem_command,
	output fetch_pkg::addr_t        proc2mem_addr,
	// line write into the cache arrays
	output logic                    fill_en,
	output logic [INDEX_BITS-1:0]   fill_index,
	output logic [TAG_BITS-1:0]     fill_tag,
	output fetch_pkg::block_t       fill_block
);

	import fetch_pkg::*;

	// clears the offset bits of a byte address
	localparam addr_t OFFSET_MASK = addr_t'((1 << BLOCK_OFFSET_BITS) - 1);

	//////////////////////////////////////////////////
	// miss state
	//////////////////////////////////////////////////

	// set one cycle after reset, no request before it
	logic     armed;
	// request issued but not yet accepted by memory
	logic     waiting;
	// request accepted, data not yet returned
	logic     pending;
	// tag that memory gave on acceptance
	mem_tag_t resp_tag;
	// block address of the request in flight
	addr_t    req_addr;

	// request for this cycle
	logic  issue;
	addr_t issue_addr;
	// memory took the request this cycle
	logic  accepted;
	// data for our request is on the bus
	logic  data_match;

	//////////////////////////////////////////////////
	// request issue and retry
	//////////////////////////////////////////////////

	// a new miss only when nothing is in flight
	// a refused request keeps going until memory takes it
	assign issue = armed && (waiting || (!lookup_hit && !pending));

	// retries use the held address, so a redirect does not move it
	assign issue_addr = waiting ? req_addr : (pc & ~OFFSET_MASK);

	// nonzero response is an accept
	assign accepted = issue && (mem2proc_response != '0);

	assign proc2mem_command = issue ? CMD_LOAD : CMD_NONE;
	assign proc2mem_addr    = issue_addr;

	//////////////////////////////////////////////////
	// data return and fill
	//////////////////////////////////////////////////

	// resp_tag is never zero while pending
	assign data_match = pending && (mem2proc_tag == resp_tag);

	// line write goes to the latched block, not to the pc
	assign fill_en    = data_match;
	assign fill_index = req_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign fill_tag   = req_addr[BLOCK_OFFSET_BITS + INDEX_BITS +: TAG_BITS];
	assign fill_block = mem2proc_data;

	//////////////////////////////////////////////////
	// state registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			armed    <= 1'b0;
			waiting  <= 1'b0;
			pending  <= 1'b0;
			resp_tag <= '0;
		end else begin
			armed <= 1'b1;
			// fill done, outstanding state cleared
			if (data_match) begin
				pending <= 1'b0;
			end
			if (accepted) begin
				// command drops to none next cycle
				waiting  <= 1'b0;
				pending  <= 1'b1;
				resp_tag <= mem2proc_response;
			end else if (issue) begin
				// refused, hold the same request
				waiting <= 1'b1;
			end
		end
	end

	// address of the request, kept until the fill
	always_ff @(posedge clock) begin
		if (issue) begin
			req_addr <= issue_addr;
		end
	end

endmodule

//--- source/fetch_pc.sv
`timescale 1ns/1ns

module fetch_pc (
	input  logic              clock,
	input  logic              rst_n,
	// control from the back end
	input  logic              stall,
	input  logic              redirect,
	input  fetch_pkg::addr_t  redirect_pc,
	// lookup result for the current pc
	input  logic              lookup_hit,
	input  fetch_pkg::block_t lookup_block,
	// fetch address and the fetched word
	output fetch_pkg::addr_t  pc,
	output logic              fetch_valid,
	output fetch_pkg::inst_t  fetch_inst
);

	import fetch_pkg::*;

	// address bit that picks the word inside a block
	localparam int WORD_SEL_BIT = BLOCK_OFFSET_BITS - 1;

	addr_t next_pc;

	//////////////////////////////////////////////////
	// next pc
	//////////////////////////////////////////////////

	// redirect first, then advance on an accepted fetch, else hold
	always_comb begin
		next_pc = pc;
		if (redirect) begin
			next_pc = redirect_pc;
		end else if (lookup_hit && !stall) begin
			next_pc = pc + addr_t'(4);
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

	//////////////////////////////////////////////////
	// fetch outputs
	//////////////////////////////////////////////////

	// hit is the valid, a miss just waits for the fill
	assign fetch_valid = lookup_hit;

	// upper word for bit 2 set
	assign fetch_inst = pc[WORD_SEL_BIT] ? lookup_block[63:32] : lookup_block[31:0];

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
	parameter int INDEX_BITS = 5,
	parameter int TAG_BITS   = 8
) (
	input  logic                    clock,
	input  logic                    rst_n,
	// back end control
	input  logic                    stall,
	input  logic                    redirect,
	input  fetch_pkg::addr_t        redirect_pc,
	// memory answers
	input  fetch_pkg::mem_tag_t     mem2proc_response,
	input  fetch_pkg::mem_tag_t     mem2proc_tag,
	input  fetch_pkg::block_t       mem2proc_data,
	// memory request
	output fetch_pkg::mem_command_t proc2mem_command,
	output fetch_pkg::addr_t        proc2mem_addr,
	// one instruction per cycle
	output logic                    fetch_valid,
	output fetch_pkg::addr_t        fetch_pc,
	output fetch_pkg::inst_t        fetch_inst
);

	import fetch_pkg::*;

	// lookup result, shared by pc logic and controller
	logic                  lookup_hit;
	block_t                lookup_block;

	// controller to arrays
	logic                  fill_en;
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0]   fill_tag;
	block_t                fill_block;

	//////////////////////////////////////////////////
	// cache arrays
	//////////////////////////////////////////////////

	icache_mem #(
		.INDEX_BITS (INDEX_BITS),
		.TAG_BITS   (TAG_BITS)
	) icache_mem_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.pc           (fetch_pc),
		.fill_en      (fill_en),
		.fill_index   (fill_index),
		.fill_tag     (fill_tag),
		.fill_block   (fill_block),
		.lookup_hit   (lookup_hit),
		.lookup_block (lookup_block)
	);

	//////////////////////////////////////////////////
	// miss handling, memory side
	//////////////////////////////////////////////////

	icache_ctrl #(
		.INDEX_BITS (INDEX_BITS),
		.TAG_BITS   (TAG_BITS)
	) icache_ctrl_i (
		.clock             (clock),
		.rst_n             (rst_n),
		.pc                (fetch_pc),
		.lookup_hit        (lookup_hit),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.fill_en           (fill_en),
		.fill_index        (fill_index),
		.fill_tag          (fill_tag),
		.fill_block        (fill_block)
	);

	//////////////////////////////////////////////////
	// program counter
	//////////////////////////////////////////////////

	// the pc register is the fetch_pc output
	fetch_pc fetch_pc_i (
		.clock        (clock),
		.rst_n        (rst_n),
		.stall        (stall),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.lookup_hit   (lookup_hit),
		.lookup_block (lookup_block),
		.pc           (fetch_pc),
		.fetch_valid  (fetch_valid),
		.fetch_inst   (fetch_inst)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clock
);

	// free running, low at time zero
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

endmodule

//--- dv/fetch_properties.sv
`timescale 1ns/1ns

module fetch_properties (
	input logic                    clock,
	input logic                    rst_n,
	input fetch_pkg::mem_command_t proc2mem_command,
	input fetch_pkg::addr_t        proc2mem_addr,
	input fetch_pkg::mem_tag_t     mem2proc_response,
	input logic                    fetch_valid
);

	import fetch_pkg::*;

	// count of assertion failures
	int unsigned fail_count = 0;

	//////////////////////////////////////////////////
	// memory request protocol
	//////////////////////////////////////////////////

	// load address is block aligned
	load_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		proc2mem_command == CMD_LOAD |-> proc2mem_addr[BLOCK_OFFSET_BITS-1:0] == '0)
	else begin
		$error("load address has offset bits set");
		fail_count++;
	end

	// refused load comes back unchanged
	load_retry: assert property (@(posedge clock) disable iff (!rst_n)
		(proc2mem_command == CMD_LOAD && mem2proc_response == '0)
		|=> (proc2mem_command == CMD_LOAD && proc2mem_addr == $past(proc2mem_addr)))
	else begin
		$error("refused load was not repeated with the same address");
		fail_count++;
	end

	// fetch valid always known out of reset
	valid_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(fetch_valid))
	else begin
		$error("fetch_valid is unknown");
		fail_count++;
	end

endmodule

bind fetch_top fetch_properties fetch_properties_i (.*);

//--- dv/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

	import fetch_pkg::*;

	localparam int INDEX_BITS      = 5;
	localparam int TAG_BITS        = 8;
	localparam int NUM_LINES       = 1 << INDEX_BITS;
	localparam int NUM_FETCHES     = 1500;
	// about 20 cycles per fetch covers misses and stalls
	localparam int WATCHDOG_CYCLES = NUM_FETCHES * 20 + 1000;

	logic         clock;
	logic         rst_n;
	logic         stall;
	logic         redirect;
	addr_t        redirect_pc;
	mem_tag_t     mem2proc_response;
	mem_tag_t     mem2proc_tag;
	block_t       mem2proc_data;
	mem_command_t proc2mem_command;
	addr_t        proc2mem_addr;
	logic         fetch_valid;
	addr_t        fetch_pc;
	inst_t        fetch_inst;

	// cache model of which tag each index holds
	bit                  model_valid [NUM_LINES];
	logic [TAG_BITS-1:0] model_tag   [NUM_LINES];

	tb_clock #(.PERIOD(40)) tb_clock_i (.clock(clock));

	fetch_top #(
		.INDEX_BITS (INDEX_BITS),
		.TAG_BITS   (TAG_BITS)
	) fetch_top_i (.*);

	//////////////////////////////////////////////////
	// reference functions
	//////////////////////////////////////////////////

	// memory word hashed from the whole address
	function automatic inst_t word_at(addr_t addr);
		return (addr * 32'h9e37_79b1) ^ (addr >> 5) ^ 32'h5bd1_e995;
	endfunction

	// block around addr with the lower word first
	function automatic block_t block_at(addr_t addr);
		addr_t base;
		base = {addr[31:3], 3'b000};
		return {word_at(base + 32'd4), word_at(base)};
	endfunction

	// hit in the cache model
	function automatic bit model_has(addr_t addr);
		logic [INDEX_BITS-1:0] idx;
		idx = addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
		return model_valid[idx]
			&& (model_tag[idx] == addr[BLOCK_OFFSET_BITS + INDEX_BITS +: TAG_BITS]);
	endfunction

	task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s, expected %0h, actual %0h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("the run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$fatal(1, "timeout");
	end

	//////////////////////////////////////////////////
	// stimulus, memory model and checks
	//////////////////////////////////////////////////

	initial begin
		addr_t       expected_pc;
		addr_t       ret_addr;
		addr_t       held_addr;
		mem_tag_t    next_tag;
		mem_tag_t    ret_tag;
		int          accept_wait;
		int          ret_wait;
		bit          ret_busy;
		bit          held;
		bit          hit;
		bit          first;
		int          fetches;
		int          loads;

		void'($urandom(32'h22d0));
		rst_n = 1'b0;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		mem2proc_response = '0;
		mem2proc_tag = '0;
		mem2proc_data = '0;
		expected_pc = RESET_PC;
		ret_addr = '0;
		held_addr = '0;
		next_tag = 4'd1;
		ret_tag = '0;
		accept_wait = $urandom % 4;
		ret_wait = 0;
		ret_busy = 1'b0;
		held = 1'b0;
		first = 1'b1;
		fetches = 0;
		loads = 0;

		// ten edges in reset with the last one below
		repeat (9) begin
			@(negedge clock);
			check_value("command in reset", CMD_NONE, proc2mem_command);
			check_value("fetch valid in reset", 0, fetch_valid);
		end
		@(posedge clock);
		#5;
		rst_n = 1'b1;

		while (fetches < NUM_FETCHES) begin
			// outputs settled mid cycle
			@(negedge clock);
			hit = model_has(expected_pc);
			check_value("fetch pc", expected_pc, fetch_pc);
			check_value("fetch valid", hit, fetch_valid);
			if (hit) begin
				check_value("fetch instruction", word_at(expected_pc), fetch_inst);
			end
			if (first) begin
				check_value("command after reset", CMD_NONE, proc2mem_command);
			end
			first = 1'b0;
			check_value("request properties", 0, fetch_top_i.fetch_properties_i.fail_count);

			// a load is only for a block the model lacks
			if (proc2mem_command == CMD_LOAD) begin
				check_value("load of a cached block", 0, model_has(proc2mem_addr));
				// new request for the pc block, a refused one keeps its address
				check_value("load address",
					held ? held_addr : {expected_pc[31:3], 3'b000}, proc2mem_addr);
				if (mem2proc_response != '0) begin
					check_value("second outstanding load", 0, ret_busy);
					ret_busy = 1'b1;
					ret_tag = mem2proc_response;
					ret_addr = proc2mem_addr;
					ret_wait = 1 + $urandom % 6;
					next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
					accept_wait = $urandom % 4;
					held = 1'b0;
					loads++;
				end else begin
					held = 1'b1;
					held_addr = proc2mem_addr;
					if (accept_wait > 0) begin
						accept_wait--;
					end
				end
			end

			// returned tag means the line is written at this edge
			if (mem2proc_tag != '0) begin
				model_valid[ret_addr[BLOCK_OFFSET_BITS +: INDEX_BITS]] = 1'b1;
				model_tag[ret_addr[BLOCK_OFFSET_BITS +: INDEX_BITS]] =
					ret_addr[BLOCK_OFFSET_BITS + INDEX_BITS +: TAG_BITS];
			end

			// redirect wins over stall and hit
			if (hit && !stall) begin
				fetches++;
			end
			if (redirect) begin
				expected_pc = redirect_pc;
			end else if (hit && !stall) begin
				expected_pc = expected_pc + 32'd4;
			end

			@(posedge clock);
			#5;
			stall = ($urandom % 4) == 0;
			redirect = ($urandom % 24) == 0;
			// half the targets are 256 bytes away at the same index with another tag
			redirect_pc = ($urandom % 2) ? (expected_pc ^ 32'h100) : ($urandom & 32'h7ffc);
			mem2proc_response = (accept_wait == 0) ? next_tag : 4'd0;
			if (ret_busy && ret_wait == 1) begin
				mem2proc_tag = ret_tag;
				mem2proc_data = block_at(ret_addr);
				ret_busy = 1'b0;
			end else begin
				// junk data that must not reach a line
				mem2proc_tag = '0;
				mem2proc_data = {$urandom, $urandom};
				ret_wait = ret_wait - 1;
			end
		end

		// assertions at the last edge
		check_value("request properties", 0, fetch_top_i.fetch_properties_i.fail_count);

		$display("%0d fetches checked, %0d loads accepted", fetches, loads);
		$display("Everything OK");
		$finish;
	end

endmodule

//--- compile.f
source/fetch_pkg.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/fetch_pc.sv
source/fetch_top.sv
dv/tb_clock.sv
dv/fetch_properties.sv
dv/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  # instruction fetch RTL, package first
  - source/fetch_pkg.sv
  - source/icache_mem.sv
  - source/icache_ctrl.sv
  - source/fetch_pc.sv
  - source/fetch_top.sv
  # testbench, top module fetch_tb
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/fetch_properties.sv
      - dv/fetch_tb.sv
